// ==== all.f ====
verilog/tile_ctrl_pkg.sv
verilog/step_sequencer.sv
verilog/tile_walker.sv
verilog/issue_gate.sv
verilog/tile_ctrl_top.sv
bench/tb_clock.sv
bench/tb_tile_ctrl.sv

// ==== bench/tb_tile_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tile controller testbench with random jobs and valids from an LCG
// reference model of steps, tile counters and in-flight outputs, watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_tile_ctrl;

  localparam int unsigned NumJobs = 12;

  logic                     clk;
  logic                     rst_n;
  tile_ctrl_pkg::ctrl_t     ctrl;
  logic                     inp_valid, weight_valid, bias_valid, oup_valid, oup_ready;
  logic                     inp_ready, weight_ready, bias_ready, calc_en, busy;
  tile_ctrl_pkg::step_e     step;
  tile_ctrl_pkg::tile_pos_t pos;

  tile_ctrl_pkg::step_e m_step;          // model state
  int unsigned          m_s, m_e, m_f, m_p;
  int unsigned          m_beat, m_inner, m_x, m_y;
  int unsigned          m_inflight;
  int unsigned          step_beats;      // dut calc_en_o beats in this step
  int unsigned          jobs_started, jobs_done;
  int unsigned          full_hits, reopen_hits;
  int unsigned          ready_left;      // cycles left in the oup_ready stretch
  logic [31:0]          seed;

  tb_clock i_clock (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  tile_ctrl_top uut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .ctrl_i         (ctrl),
    .inp_valid_i    (inp_valid),
    .weight_valid_i (weight_valid),
    .bias_valid_i   (bias_valid),
    .oup_valid_i    (oup_valid),
    .oup_ready_i    (oup_ready),
    .inp_ready_o    (inp_ready),
    .weight_ready_o (weight_ready),
    .bias_ready_o   (bias_ready),
    .calc_en_o      (calc_en),
    .step_o         (step),
    .pos_o          (pos),
    .busy_o         (busy)
  );

  function automatic int unsigned rand_below(input int unsigned range);
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed[31:16] % range;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected == actual) else
      fail_run($sformatf("Mismatch at %0d ns: %s expected %0h actual %0h",
                         $time, name, expected, actual));
  endtask

  // inner, x and y loop bounds of the model's step
  task automatic get_bounds(output int unsigned inner, output int unsigned x,
                            output int unsigned y);
    inner = 0;
    x     = 0;
    y     = 0;
    case (m_step)
      tile_ctrl_pkg::MatMul: begin
        inner = m_e;
        x     = m_p;
        y     = m_s;
      end
      tile_ctrl_pkg::F1: begin
        inner = m_e;
        x     = m_f;
        y     = m_s;
      end
      tile_ctrl_pkg::F2: begin
        inner = m_f;
        x     = m_e;
        y     = m_s;
      end
      default: inner = 0;
    endcase
  endtask

  function automatic logic gate_open();
    return (m_step != tile_ctrl_pkg::Idle) && (m_inflight < tile_ctrl_pkg::FifoDepth);
  endfunction

  // model update for the rising edge that just passed
  task automatic advance_model();
    int unsigned inner, x, y;
    logic        calc, issue, leave, done;
    get_bounds(inner, x, y);
    calc  = gate_open() && inp_valid && weight_valid && bias_valid;
    issue = calc && (m_inner == inner - 1);
    leave = oup_valid && oup_ready;
    done  = calc && (m_beat == tile_ctrl_pkg::TileBeats - 1) && (m_inner == inner - 1) &&
            (m_x == x - 1) && (m_y == y - 1);
    if (leave && m_inflight == tile_ctrl_pkg::FifoDepth) reopen_hits++;
    if (issue && !leave) m_inflight++;
    else if (leave && !issue) m_inflight--;
    if (calc) begin
      m_beat++;
      if (m_beat == tile_ctrl_pkg::TileBeats) begin
        m_beat = 0;
        m_inner++;
        if (m_inner == inner) begin
          m_inner = 0;
          m_x++;
          if (m_x == x) begin  // x wraps into y
            m_x = 0;
            m_y++;
            if (m_y == y) m_y = 0;
          end
        end
      end
    end
    if (m_step == tile_ctrl_pkg::Idle) begin
      if (ctrl.start) begin
        m_s    = ctrl.tile_s;
        m_e    = ctrl.tile_e;
        m_f    = ctrl.tile_f;
        m_p    = ctrl.tile_p;
        m_step = (ctrl.layer == tile_ctrl_pkg::Feedforward) ? tile_ctrl_pkg::F1
                                                            : tile_ctrl_pkg::MatMul;
      end
    end else if (done) begin
      check_value("calc_en_o beats per step", inner * x * y * tile_ctrl_pkg::TileBeats,
                  step_beats);
      step_beats = 0;
      if (m_step == tile_ctrl_pkg::F1) begin
        m_step = tile_ctrl_pkg::F2;
      end else begin
        m_step = tile_ctrl_pkg::Idle;
        jobs_done++;
      end
    end
  endtask

  task automatic random_job();
    ctrl.start  = 1'b1;
    ctrl.layer  = rand_below(2) ? tile_ctrl_pkg::Feedforward : tile_ctrl_pkg::Linear;
    ctrl.tile_s = tile_ctrl_pkg::counter_t'(1 + rand_below(2));
    ctrl.tile_e = tile_ctrl_pkg::counter_t'(1 + rand_below(2));
    ctrl.tile_f = tile_ctrl_pkg::counter_t'(1 + rand_below(2));
    ctrl.tile_p = tile_ctrl_pkg::counter_t'(1 + rand_below(2));
  endtask

  task automatic drive_inputs();
    ctrl.start = 1'b0;
    if (m_step == tile_ctrl_pkg::Idle) begin
      if (jobs_started < NumJobs && rand_below(2) == 0) begin
        random_job();
        jobs_started++;
      end
    end else if (rand_below(64) == 0) begin
      random_job();  // must be ignored while running
    end
    inp_valid    = rand_below(10) < 7;
    weight_valid = rand_below(10) < 7;
    bias_valid   = rand_below(10) < 7;
    if (ready_left == 0) begin
      oup_ready  = !oup_ready;
      ready_left = oup_ready ? 8 + rand_below(64) : 16 + rand_below(48);
    end else begin
      ready_left--;
    end
    oup_valid = (m_inflight > 0) && (rand_below(10) < 7);
  endtask

  task automatic check_outputs();
    int unsigned inner, x, y;
    logic        open;
    get_bounds(inner, x, y);
    open = gate_open();
    check_value("step_o", m_step, step);
    check_value("busy_o", m_step != tile_ctrl_pkg::Idle, busy);
    check_value("inp_ready_o", open && weight_valid, inp_ready);
    check_value("weight_ready_o", open && inp_valid, weight_ready);
    check_value("bias_ready_o", open && weight_valid, bias_ready);
    check_value("calc_en_o", open && inp_valid && weight_valid && bias_valid, calc_en);
    if (calc_en) step_beats++;
    check_value("pos_o.inner_tile", m_inner, pos.inner_tile);
    check_value("pos_o.tile_x", m_x, pos.tile_x);
    check_value("pos_o.tile_y", m_y, pos.tile_y);
    check_value("pos_o.first_inner", m_inner == 0, pos.first_inner);
    check_value("pos_o.last_inner", m_step != tile_ctrl_pkg::Idle && m_inner == inner - 1,
                pos.last_inner);
    if (m_step != tile_ctrl_pkg::Idle && m_inflight == tile_ctrl_pkg::FifoDepth) full_hits++;
  endtask

  initial begin
    seed         = 32'hedf1a70e;
    ctrl         = '0;
    inp_valid    = 1'b0;
    weight_valid = 1'b0;
    bias_valid   = 1'b0;
    oup_valid    = 1'b0;
    oup_ready    = 1'b1;
    ready_left   = 16;
    m_step       = tile_ctrl_pkg::Idle;
    {m_s, m_e, m_f, m_p}         = '0;
    {m_beat, m_inner, m_x, m_y}  = '0;
    m_inflight   = 0;
    step_beats   = 0;
    jobs_started = 0;
    jobs_done    = 0;
    full_hits    = 0;
    reopen_hits  = 0;
    @(posedge rst_n);
    while (jobs_done < NumJobs) begin
      @(posedge clk);
      advance_model();
      #1;
      drive_inputs();
      #2;  // outputs settled
      check_outputs();
    end
    if (full_hits > 0 && reopen_hits > 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      fail_run("back-pressure never filled the output FIFO and reopened it");
    end
  end

  // worst case is two steps of 8 tiles per job at 8 cycles per beat
  initial begin
    int unsigned limit;
    limit = NumJobs * 2 * 8 * tile_ctrl_pkg::TileBeats * 8;
    repeat (limit) @(posedge clk);
    fail_run("watchdog expired, the jobs did not finish in time");
  end

endmodule

// ==== bench/tb_clock.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bench clock with a 4 ns period and reset generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // reset held over two rising edges
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

// ==== verilog/tile_ctrl_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tile controller top level wiring the step sequencer, tile walker and issue gate
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tile_ctrl_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  tile_ctrl_pkg::ctrl_t     ctrl_i,
  input  logic                     inp_valid_i,
  input  logic                     weight_valid_i,
  input  logic                     bias_valid_i,
  input  logic                     oup_valid_i,
  input  logic                     oup_ready_i,
  output logic                     inp_ready_o,
  output logic                     weight_ready_o,
  output logic                     bias_ready_o,
  output logic                     calc_en_o,
  output tile_ctrl_pkg::step_e     step_o,
  output tile_ctrl_pkg::tile_pos_t pos_o,
  output logic                     busy_o
);

  tile_ctrl_pkg::step_e      step;
  tile_ctrl_pkg::bounds_t    bounds;
  tile_ctrl_pkg::tile_pos_t  pos;
  logic                      calc_en;
  logic                      step_done;

  assign step_o    = step;
  assign pos_o     = pos;
  assign calc_en_o = calc_en;

  step_sequencer i_step_sequencer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ctrl_i      (ctrl_i),
    .step_done_i (step_done),
    .step_o      (step),
    .bounds_o    (bounds),
    .busy_o      (busy_o)
  );

  tile_walker i_tile_walker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .step_i      (step),
    .bounds_i    (bounds),
    .calc_en_i   (calc_en),
    .pos_o       (pos),
    .step_done_o (step_done)
  );

  issue_gate i_issue_gate (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .step_i         (step),
    .pos_i          (pos),
    .inp_valid_i    (inp_valid_i),
    .weight_valid_i (weight_valid_i),
    .bias_valid_i   (bias_valid_i),
    .oup_valid_i    (oup_valid_i),
    .oup_ready_i    (oup_ready_i),
    .inp_ready_o    (inp_ready_o),
    .weight_ready_o (weight_ready_o),
    .bias_ready_o   (bias_ready_o),
    .calc_en_o      (calc_en)
  );

endmodule

// ==== verilog/issue_gate.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cross coupled readies and compute enable of the issue gate
// in-flight output count against the output FIFO depth
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module issue_gate (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  tile_ctrl_pkg::step_e     step_i,
  input  tile_ctrl_pkg::tile_pos_t pos_i,
  input  logic                     inp_valid_i,
  input  logic                     weight_valid_i,
  input  logic                     bias_valid_i,
  input  logic                     oup_valid_i,
  input  logic                     oup_ready_i,
  output logic                     inp_ready_o,
  output logic                     weight_ready_o,
  output logic                     bias_ready_o,
  output logic                     calc_en_o
);

  tile_ctrl_pkg::counter_t inflight_q;
  logic                    gate_open;
  logic                    issue;  // beat that makes an output
  logic                    leave;

  assign gate_open = (step_i != tile_ctrl_pkg::Idle) &&
                     (inflight_q < tile_ctrl_pkg::counter_t'(tile_ctrl_pkg::FifoDepth));

  always_comb begin
    inp_ready_o    = 1'b0;
    weight_ready_o = 1'b0;
    bias_ready_o   = 1'b0;
    if (gate_open) begin
      inp_ready_o    = weight_valid_i;  // cross coupled
      weight_ready_o = inp_valid_i;
      bias_ready_o   = weight_valid_i;
    end
  end

  assign calc_en_o = gate_open && inp_valid_i && weight_valid_i && bias_valid_i;

  // only the last inner tile produces results
  assign issue = calc_en_o && pos_i.last_inner;
  assign leave = oup_valid_i && oup_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= '0;
    end else if (issue && !leave) begin
      inflight_q <= inflight_q + 1'b1;
    end else if (leave && !issue) begin
      inflight_q <= inflight_q - 1'b1;
    end
  end

  a_inflight_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
    inflight_q <= tile_ctrl_pkg::counter_t'(tile_ctrl_pkg::FifoDepth));

  // downstream never pops an output that was not issued
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    leave && !issue |-> inflight_q != '0);

endmodule

// ==== verilog/tile_walker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// beat, inner tile and outer tile counters,
// end of tile and end of step detection
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tile_walker (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  tile_ctrl_pkg::step_e     step_i,
  input  tile_ctrl_pkg::bounds_t   bounds_i,
  input  logic                     calc_en_i,
  output tile_ctrl_pkg::tile_pos_t pos_o,
  output logic                     step_done_o
);

  tile_ctrl_pkg::counter_t beat_q;
  tile_ctrl_pkg::counter_t inner_q;
  tile_ctrl_pkg::counter_t x_q;
  tile_ctrl_pkg::counter_t y_q;
  tile_ctrl_pkg::counter_t inner_end, x_end, y_end;
  logic                    last_beat, last_inner, last_x, last_y;

  assign inner_end = bounds_i.inner_dim - 1'b1;
  assign x_end     = bounds_i.x_dim - 1'b1;
  assign y_end     = bounds_i.y_dim - 1'b1;

  assign last_beat  = (beat_q == tile_ctrl_pkg::counter_t'(tile_ctrl_pkg::TileBeats - 1));
  assign last_inner = (inner_q == inner_end);
  assign last_x     = (x_q == x_end);
  assign last_y     = (y_q == y_end);

  // final beat of the final output tile
  assign step_done_o = calc_en_i && last_beat && last_inner && last_x && last_y;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_q  <= '0;
      inner_q <= '0;
      x_q     <= '0;
      y_q     <= '0;
    end else if (step_i == tile_ctrl_pkg::Idle) begin
      beat_q  <= '0;
      inner_q <= '0;
      x_q     <= '0;
      y_q     <= '0;
    end else if (calc_en_i) begin
      if (last_beat) begin
        beat_q <= '0;
        if (last_inner) begin
          inner_q <= '0;
          if (last_x) begin  // x wraps before y
            x_q <= '0;
            y_q <= last_y ? '0 : y_q + 1'b1;
          end else begin
            x_q <= x_q + 1'b1;
          end
        end else begin
          inner_q <= inner_q + 1'b1;
        end
      end else begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  always_comb begin
    pos_o             = '0;
    pos_o.inner_tile  = inner_q;
    pos_o.tile_x      = x_q;
    pos_o.tile_y      = y_q;
    pos_o.first_inner = (inner_q == '0);
    pos_o.last_inner  = last_inner;  // low in idle where the bounds are zero
  end

  // outer position stays inside the step's output grid
  a_tile_x_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    step_i != tile_ctrl_pkg::Idle |-> pos_o.tile_x < bounds_i.x_dim);

endmodule

// ==== verilog/step_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// layer step FSM with per-step loop bounds
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module step_sequencer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  tile_ctrl_pkg::ctrl_t   ctrl_i,
  input  logic                   step_done_i,
  output tile_ctrl_pkg::step_e   step_o,
  output tile_ctrl_pkg::bounds_t bounds_o,
  output logic                   busy_o
);

  tile_ctrl_pkg::step_e    step_d, step_q;
  tile_ctrl_pkg::counter_t tile_s_q, tile_e_q, tile_f_q, tile_p_q;
  logic                    accept;

  assign accept = ctrl_i.start && (step_q == tile_ctrl_pkg::Idle);

  always_comb begin
    step_d = step_q;
    case (step_q)
      tile_ctrl_pkg::Idle: begin
        if (accept) begin
          step_d = (ctrl_i.layer == tile_ctrl_pkg::Feedforward) ? tile_ctrl_pkg::F1
                                                                 : tile_ctrl_pkg::MatMul;
        end
      end
      tile_ctrl_pkg::MatMul: if (step_done_i) step_d = tile_ctrl_pkg::Idle;
      tile_ctrl_pkg::F1:     if (step_done_i) step_d = tile_ctrl_pkg::F2;
      tile_ctrl_pkg::F2:     if (step_done_i) step_d = tile_ctrl_pkg::Idle;
      default:               step_d = tile_ctrl_pkg::Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_q <= tile_ctrl_pkg::Idle;
    end else begin
      step_q <= step_d;
    end
  end

  // job sizes held for the whole layer
  always_ff @(posedge clk_i) begin
    if (accept) begin
      tile_s_q <= ctrl_i.tile_s;
      tile_e_q <= ctrl_i.tile_e;
      tile_f_q <= ctrl_i.tile_f;
      tile_p_q <= ctrl_i.tile_p;
    end
  end

  always_comb begin
    bounds_o = '0;
    case (step_q)
      tile_ctrl_pkg::MatMul: begin
        bounds_o.inner_dim = tile_e_q;
        bounds_o.x_dim     = tile_p_q;
        bounds_o.y_dim     = tile_s_q;
      end
      tile_ctrl_pkg::F1: begin
        bounds_o.inner_dim = tile_e_q;
        bounds_o.x_dim     = tile_f_q;  // hidden width
        bounds_o.y_dim     = tile_s_q;
      end
      tile_ctrl_pkg::F2: begin
        bounds_o.inner_dim = tile_f_q;
        bounds_o.x_dim     = tile_e_q;
        bounds_o.y_dim     = tile_s_q;
      end
      default: bounds_o = '0;
    endcase
  end

  assign step_o = step_q;
  assign busy_o = (step_q != tile_ctrl_pkg::Idle);

  // walker ends only a running step
  a_done_not_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    step_done_i |-> step_q != tile_ctrl_pkg::Idle);

  a_bounds_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    step_q != tile_ctrl_pkg::Idle |->
      bounds_o.inner_dim != '0 && bounds_o.x_dim != '0 && bounds_o.y_dim != '0);

endmodule

// ==== verilog/tile_ctrl_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizes, layer and step enums of the tile controller
// job description, loop bound and tile position structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package tile_ctrl_pkg;

  localparam int unsigned N         = 4;          // lanes per beat
  localparam int unsigned M         = 16;         // tile edge
  localparam int unsigned TileBeats = M * M / N;  // beats per tile
  localparam int unsigned FifoDepth = 8;          // output fifo entries
  localparam int unsigned CntW      = 8;

  typedef logic [CntW-1:0] counter_t;

  typedef enum logic {
    Linear,
    Feedforward
  } layer_e;

  // one step per matmul pass
  typedef enum logic [1:0] {
    Idle,
    MatMul,
    F1,
    F2
  } step_e;

  typedef struct packed {
    logic     start;   // single cycle
    layer_e   layer;
    counter_t tile_s;  // sequence tiles
    counter_t tile_e;  // embedding tiles
    counter_t tile_f;  // feedforward tiles
    counter_t tile_p;  // projection tiles
  } ctrl_t;

  // loop bounds of the running step, all in tiles
  typedef struct packed {
    counter_t inner_dim;
    counter_t x_dim;
    counter_t y_dim;
  } bounds_t;

  typedef struct packed {
    counter_t inner_tile;
    counter_t tile_x;
    counter_t tile_y;
    logic     first_inner;
    logic     last_inner;
  } tile_pos_t;

endpackage
